// ==== files.f ====
hw/lm80c_pkg.sv
hw/clock_enable_gen.sv
hw/io_decoder.sv
hw/io_slot.sv
hw/led_port.sv
hw/boot_arbiter.sv
hw/system_ram.sv
hw/cpu_read_mux.sv
hw/lm80c_bus_top.sv
verification/lm80c_bus_tb.sv

// ==== verification/lm80c_bus_tb.sv ====
/*
 * LM80C bus glue testbench
 * Table of CPU and downloader bus states with expected results, each
 * step held for six RAM clock cycles and checked on the last one
 */
`timescale 1ns/1ps
`default_nettype none

module lm80c_bus_tb import lm80c_pkg::*; ();

	localparam int          CLK_PERIOD      = 40;
	localparam int          DRIVE_DELAY     = 2;
	localparam int          RESET_CYCLES    = 5;
	localparam int          CYCLES_PER_STEP = 6;
	localparam int          WATCHDOG_SLACK  = 100;
	localparam logic [31:0] SEED            = 32'h30a2_defd;

	// One table row, stimulus first, then the expected results
	typedef struct packed {
		load_req_t                load;
		cpu_bus_t                 bus;
		logic                     boot_done;
		data_t [NUM_IO_SLOTS-1:0] periph;
		data_t                    int_vector;
		data_t                    exp_rdata;
		slot_mask_t               exp_rd_n;
		slot_mask_t               exp_wr_n;
		logic                     exp_led;
		logic                     exp_wait;
	} step_t;

	logic       ram_clock;
	logic       RESET;
	cpu_bus_t   cpu_bus;
	load_req_t  load;
	data_t      periph_rdata [NUM_IO_SLOTS];
	data_t      int_vector;
	logic       boot_done;
	logic       reset_key;
	logic       cpu_ce;
	logic       vdp_ce;
	logic       cpu_wait;
	logic       cpu_reset;
	data_t      cpu_rdata;
	slot_mask_t periph_rd_n;
	slot_mask_t periph_wr_n;
	logic       led;

	step_t steps [$];
	logic  table_ready = 1'b0;
	int    step_idx    = -1;

	// Reference state while the table is built
	data_t model_mem [65536];
	data_t model_led;
	data_t model_rdata;
	logic  model_boot_done;

	lm80c_bus_top dut0 (
		.ram_clock      (ram_clock),
		.RESET          (RESET),
		.cpu_bus_i      (cpu_bus),
		.load_i         (load),
		.periph_rdata_i (periph_rdata),
		.int_vector_i   (int_vector),
		.boot_done_i    (boot_done),
		.reset_key_i    (reset_key),
		.cpu_ce_o       (cpu_ce),
		.vdp_ce_o       (vdp_ce),
		.cpu_wait_o     (cpu_wait),
		.cpu_reset_o    (cpu_reset),
		.cpu_rdata_o    (cpu_rdata),
		.periph_rd_n_o  (periph_rd_n),
		.periph_wr_n_o  (periph_wr_n),
		.led_o          (led)
	);

	initial ram_clock = 1'b0;
	always #(CLK_PERIOD / 2) ram_clock = ~ram_clock;

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Verification failed");
		$fatal(1, "Simulation stopped on error");
	endtask

	task automatic check_data(input string name, input data_t got, input data_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAILED at %0t: %s = 0x%h, expected 0x%h (step %0d)",
				$time, name, got, exp, step_idx));
		end
	endtask

	task automatic check_mask(input string name, input slot_mask_t got, input slot_mask_t exp);
		if (got !== exp) begin
			abort_run($sformatf("FAILED at %0t: %s = %b, expected %b (step %0d)",
				$time, name, got, exp, step_idx));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			abort_run($sformatf("FAILED at %0t: %s = %b, expected %b (step %0d)",
				$time, name, got, exp, step_idx));
		end
	endtask

	// Idle bus, fresh peripheral bytes and vector
	function automatic step_t new_step();
		step_t s;
		s = '0;
		s.boot_done = model_boot_done;
		for (int i = 0; i < NUM_IO_SLOTS; i++) begin
			s.periph[i] = data_t'($urandom);
		end
		s.int_vector = data_t'($urandom);
		s.exp_rd_n   = '1;
		s.exp_wr_n   = '1;
		return s;
	endfunction

	// Read byte holds between reads, CPU stalled until boot done and load idle
	function automatic void push_step(step_t s);
		s.exp_rdata = model_rdata;
		s.exp_led   = (model_led != 8'h00);
		s.exp_wait  = !(s.boot_done && !s.load.active);
		steps.push_back(s);
	endfunction

	function automatic void add_load(input addr_t addr, input data_t data, input logic done);
		step_t s;
		model_boot_done = done;
		s = new_step();
		s.load.active = 1'b1;
		s.load.addr   = addr;
		s.load.data   = data;
		s.load.wr     = 1'b1;
		model_mem[addr] = data;
		push_step(s);
	endfunction

	function automatic void add_idle(input logic done);
		model_boot_done = done;
		push_step(new_step());
	endfunction

	function automatic void add_mem_write(input addr_t addr, input data_t data);
		step_t s;
		s = new_step();
		s.bus.addr  = addr;
		s.bus.wdata = data;
		s.bus.mreq  = 1'b1;
		s.bus.wr    = 1'b1;
		// ROM image below and above the window is not writable by the CPU
		if (addr >= RAM_WIN_LO && addr < RAM_WIN_HI) begin
			model_mem[addr] = data;
		end
		push_step(s);
	endfunction

	function automatic void add_mem_read(input addr_t addr);
		step_t s;
		s = new_step();
		s.bus.addr = addr;
		s.bus.mreq = 1'b1;
		s.bus.rd   = 1'b1;
		model_rdata = model_mem[addr];
		push_step(s);
	endfunction

	// Port n*16 belongs to slot n
	function automatic void add_io(input addr_t port, input logic wr, input data_t data);
		step_t s;
		s = new_step();
		s.bus.addr  = port;
		s.bus.wdata = data;
		s.bus.iorq  = 1'b1;
		s.bus.wr    = wr;
		s.bus.rd    = !wr;
		if (port[7:4] < NUM_IO_SLOTS) begin
			if (wr) begin
				s.exp_wr_n[port[7:4]] = 1'b0;
			end else begin
				s.exp_rd_n[port[7:4]] = 1'b0;
				model_rdata = s.periph[port[7:4]];
			end
		end
		if (port[7:0] == LED_PORT) begin
			if (wr) begin
				model_led = data;
			end else begin
				model_rdata = model_led;
			end
		end
		push_step(s);
	endfunction

	// IORQ with M1 and no read strobe, port outside every slot
	function automatic void add_int_ack();
		step_t s;
		s = new_step();
		s.bus.addr = 16'h0080;
		s.bus.iorq = 1'b1;
		s.bus.m1   = 1'b1;
		model_rdata = s.int_vector;
		push_step(s);
	endfunction

	function automatic void build_table();
		addr_t load_addr [4];
		addr_t win_addr;
		model_boot_done = 1'b0;
		model_led       = '0;
		model_rdata     = '0;
		// One downloaded byte per quarter of the address space
		for (int q = 0; q < 4; q++) begin
			load_addr[q] = addr_t'(q * 16'h4000) | (addr_t'($urandom) & 16'h3FFF);
			add_load(load_addr[q], data_t'($urandom), q == 3);
		end
		add_idle(1'b0);
		add_idle(1'b1);
		for (int q = 0; q < 4; q++) begin
			add_mem_read(load_addr[q]);
		end
		// Overwrite inside the window, then a random window byte
		add_mem_write(load_addr[2], data_t'($urandom));
		add_mem_read(load_addr[2]);
		win_addr = RAM_WIN_LO | (addr_t'($urandom) & 16'h3FFF);
		add_mem_write(win_addr, data_t'($urandom));
		add_mem_read(win_addr);
		// Protected bytes keep the downloaded value
		add_mem_write(load_addr[0], data_t'($urandom));
		add_mem_read(load_addr[0]);
		add_mem_write(load_addr[3], data_t'($urandom));
		add_mem_read(load_addr[3]);
		for (int n = 0; n < NUM_IO_SLOTS; n++) begin
			add_io(addr_t'(n * 16), 1'b0, '0);
			add_io(addr_t'(n * 16), 1'b1, data_t'($urandom));
		end
		add_io(16'h00FF, 1'b1, data_t'($urandom) | 8'h01);
		add_io(16'h00FF, 1'b0, '0);
		add_io(16'h00FF, 1'b1, 8'h00);
		add_io(16'h00FF, 1'b0, '0);
		add_int_ack();
		add_int_ack();
		add_mem_read(win_addr);
	endfunction

	task automatic drive_step(input step_t s);
		cpu_bus    = s.bus;
		load       = s.load;
		boot_done  = s.boot_done;
		int_vector = s.int_vector;
		for (int i = 0; i < NUM_IO_SLOTS; i++) begin
			periph_rdata[i] = s.periph[i];
		end
	endtask

	task automatic check_step(input step_t s);
		check_data("cpu_rdata_o", cpu_rdata, s.exp_rdata);
		check_mask("periph_rd_n_o", periph_rd_n, s.exp_rd_n);
		check_mask("periph_wr_n_o", periph_wr_n, s.exp_wr_n);
		check_bit("led_o", led, s.exp_led);
		check_bit("cpu_wait_o", cpu_wait, s.exp_wait);
		check_bit("cpu_reset_o", cpu_reset, s.exp_wait);
	endtask

	initial begin : watchdog
		wait (table_ready);
		#(CLK_PERIOD * (steps.size() * CYCLES_PER_STEP + WATCHDOG_SLACK));
		abort_run("Timeout: the table did not complete within the watchdog limit");
	end

	initial begin : main
		void'($urandom(SEED));
		RESET      = 1'b1;
		cpu_bus    = '0;
		load       = '0;
		int_vector = '0;
		boot_done  = 1'b0;
		reset_key  = 1'b0;
		for (int i = 0; i < NUM_IO_SLOTS; i++) begin
			periph_rdata[i] = '0;
		end
		build_table();
		table_ready = 1'b1;

		// Inactive outputs while in reset
		repeat (RESET_CYCLES - 1) @(posedge ram_clock);
		@(negedge ram_clock);
		check_mask("periph_rd_n_o", periph_rd_n, '1);
		check_mask("periph_wr_n_o", periph_wr_n, '1);
		check_bit("led_o", led, 1'b0);
		check_data("cpu_rdata_o", cpu_rdata, '0);
		check_bit("cpu_wait_o", cpu_wait, 1'b1);
		check_bit("cpu_reset_o", cpu_reset, 1'b1);
		@(posedge ram_clock);
		#DRIVE_DELAY;
		RESET = 1'b0;

		// Enable pattern from the first cycle after reset
		for (int k = 0; k < 2 * CE_PHASES; k++) begin
			@(negedge ram_clock);
			check_bit("vdp_ce_o", vdp_ce, (k % 2) == 0);
			check_bit("cpu_ce_o", cpu_ce, (k % 4) == 0);
		end

		foreach (steps[i]) begin
			step_idx = i;
			@(posedge ram_clock);
			#DRIVE_DELAY;
			drive_step(steps[i]);
			repeat (CYCLES_PER_STEP - 1) @(posedge ram_clock);
			@(negedge ram_clock);
			check_step(steps[i]);
		end

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/lm80c_bus_top.sv ====
/*
 * LM80C bus glue top
 * Clock enables, boot arbitration, system RAM, I/O decode into the
 * peripheral slots and the CPU read path
 */
`timescale 1ns/1ps
`default_nettype none

module lm80c_bus_top import lm80c_pkg::*; (
	input  logic       ram_clock,
	input  logic       RESET,
	input  cpu_bus_t   cpu_bus_i,
	input  load_req_t  load_i,
	input  data_t      periph_rdata_i [NUM_IO_SLOTS],
	input  data_t      int_vector_i,
	input  logic       boot_done_i,
	input  logic       reset_key_i,
	output logic       cpu_ce_o,
	output logic       vdp_ce_o,
	output logic       cpu_wait_o,
	output logic       cpu_reset_o,
	output data_t      cpu_rdata_o,
	output slot_mask_t periph_rd_n_o,
	output slot_mask_t periph_wr_n_o,
	output logic       led_o
);

	slot_mask_t slot_hit;
	logic       led_hit;
	logic       ram_win_hit;
	data_t      slot_rdata [NUM_IO_SLOTS];
	data_t      led_latch;
	mem_req_t   mem_req;
	data_t      ram_rdata;

	clock_enable_gen u_clock_enable_gen (
		.ram_clock (ram_clock),
		.RESET     (RESET),
		.cpu_ce_o  (cpu_ce_o),
		.vdp_ce_o  (vdp_ce_o)
	);

	io_decoder u_io_decoder (
		.ram_clock     (ram_clock),
		.RESET         (RESET),
		.bus_i         (cpu_bus_i),
		.slot_hit_o    (slot_hit),
		.led_hit_o     (led_hit),
		.ram_win_hit_o (ram_win_hit)
	);

	// PIO, CTC, SIO, VDP, PSG
	for (genvar i = 0; i < NUM_IO_SLOTS; i++) begin : g_slot
		io_slot #(
			.SLOT (slot_idx_t'(i))
		) u_io_slot (
			.ram_clock      (ram_clock),
			.RESET          (RESET),
			.hit_i          (slot_hit[i]),
			.bus_i          (cpu_bus_i),
			.periph_rdata_i (periph_rdata_i[i]),
			.rd_n_o         (periph_rd_n_o[i]),
			.wr_n_o         (periph_wr_n_o[i]),
			.rdata_o        (slot_rdata[i])
		);
	end

	led_port u_led_port (
		.ram_clock (ram_clock),
		.RESET     (RESET),
		.hit_i     (led_hit),
		.bus_i     (cpu_bus_i),
		.latch_o   (led_latch),
		.led_o     (led_o)
	);

	boot_arbiter u_boot_arbiter (
		.ram_clock     (ram_clock),
		.RESET         (RESET),
		.bus_i         (cpu_bus_i),
		.load_i        (load_i),
		.ram_win_hit_i (ram_win_hit),
		.boot_done_i   (boot_done_i),
		.reset_key_i   (reset_key_i),
		.mem_req_o     (mem_req),
		.cpu_wait_o    (cpu_wait_o),
		.cpu_reset_o   (cpu_reset_o)
	);

	system_ram u_system_ram (
		.ram_clock (ram_clock),
		.req_i     (mem_req),
		.rdata_o   (ram_rdata)
	);

	// Vector comes straight from the CTC, not through its slot
	cpu_read_mux u_cpu_read_mux (
		.ram_clock    (ram_clock),
		.RESET        (RESET),
		.bus_i        (cpu_bus_i),
		.slot_hit_i   (slot_hit),
		.led_hit_i    (led_hit),
		.slot_rdata_i (slot_rdata),
		.led_latch_i  (led_latch),
		.ram_rdata_i  (ram_rdata),
		.int_vector_i (int_vector_i),
		.rdata_o      (cpu_rdata_o)
	);

endmodule

`default_nettype wire

// ==== hw/cpu_read_mux.sv ====
/*
 * CPU read multiplexer
 * Registers the byte returned to the CPU from the hit slot, the LED
 * latch or RAM, and the interrupt vector on acknowledge
 */
`timescale 1ns/1ps
`default_nettype none

module cpu_read_mux import lm80c_pkg::*; (
	input  logic       ram_clock,
	input  logic       RESET,
	input  cpu_bus_t   bus_i,
	input  slot_mask_t slot_hit_i,
	input  logic       led_hit_i,
	input  data_t      slot_rdata_i [NUM_IO_SLOTS],
	input  data_t      led_latch_i,
	input  data_t      ram_rdata_i,
	input  data_t      int_vector_i,
	output data_t      rdata_o
);

	data_t rd_sel;
	logic  int_ack;

	// Slots win over the LED latch, RAM when nothing on I/O hits
	always_comb begin
		rd_sel = ram_rdata_i;
		if (led_hit_i) begin
			rd_sel = led_latch_i;
		end
		for (int i = 0; i < NUM_IO_SLOTS; i++) begin
			if (slot_hit_i[i]) begin
				rd_sel = slot_rdata_i[i];
			end
		end
	end

	// IORQ together with M1
	assign int_ack = bus_i.iorq & bus_i.m1;

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			rdata_o <= '0;
		end else if (bus_i.rd) begin
			rdata_o <= rd_sel;
		end else if (int_ack) begin
			rdata_o <= int_vector_i;
		end
		// Holds between accesses
	end

endmodule

`default_nettype wire

// ==== hw/system_ram.sv ====
/*
 * System RAM
 * 64 KiB synchronous single port byte RAM, read during write
 * returns the previous contents
 */
`timescale 1ns/1ps
`default_nettype none

module system_ram import lm80c_pkg::*; (
	input  logic     ram_clock,
	input  mem_req_t req_i,
	output data_t    rdata_o
);

	// Whole Z80 address space
	data_t mem [2**$bits(addr_t)];

	always_ff @(posedge ram_clock) begin
		if (req_i.wr) begin
			mem[req_i.addr] <= req_i.data;
		end
		// Old data on a same-address write
		rdata_o <= mem[req_i.addr];
	end

endmodule

`default_nettype wire

// ==== hw/boot_arbiter.sv ====
/*
 * Boot arbiter
 * Gives system RAM to the ROM downloader until boot completes and
 * holds the CPU in wait and reset meanwhile, then forwards CPU
 * accesses with writes limited to the RAM window
 */
`timescale 1ns/1ps
`default_nettype none

module boot_arbiter import lm80c_pkg::*; (
	input  logic      ram_clock,
	input  logic      RESET,
	input  cpu_bus_t  bus_i,
	input  load_req_t load_i,
	input  logic      ram_win_hit_i,
	input  logic      boot_done_i,
	input  logic      reset_key_i,
	output mem_req_t  mem_req_o,
	output logic      cpu_wait_o,
	output logic      cpu_reset_o
);

	owner_e owner_q;
	owner_e owner_d;
	addr_t  last_addr_q;
	logic   cpu_wr;

	always_comb begin
		owner_d = owner_q;
		case (owner_q)
			OWNER_LOADER: begin
				if (boot_done_i && !load_i.active) begin
					owner_d = OWNER_CPU;
				end
			end
			OWNER_CPU: begin
				// New download or lost boot takes RAM back
				if (load_i.active || !boot_done_i) begin
					owner_d = OWNER_LOADER;
				end
			end
			default: owner_d = OWNER_LOADER;
		endcase
	end

	// Window hit belongs to the previous cycle's address
	assign cpu_wr = bus_i.mreq && bus_i.wr && ram_win_hit_i && (last_addr_q == bus_i.addr);

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			owner_q   <= OWNER_LOADER;
			mem_req_o <= '0;
		end else begin
			owner_q <= owner_d;
			if (owner_q == OWNER_LOADER) begin
				mem_req_o.addr <= load_i.addr;
				mem_req_o.data <= load_i.data;
				mem_req_o.wr   <= load_i.active & load_i.wr;
			end else begin
				mem_req_o.addr <= bus_i.addr;
				mem_req_o.data <= bus_i.wdata;
				mem_req_o.wr   <= cpu_wr;
			end
		end
	end

	always_ff @(posedge ram_clock) begin
		last_addr_q <= bus_i.addr;
	end

	// CPU stalled and reset while the loader owns RAM
	assign cpu_wait_o  = (owner_q == OWNER_LOADER);
	assign cpu_reset_o = cpu_wait_o | reset_key_i;

	// ROM image below the window stays intact
	a_cpu_wr_window : assert property (@(posedge ram_clock) disable iff (RESET)
		($past(owner_q) == OWNER_CPU && mem_req_o.wr) |->
		(mem_req_o.addr >= RAM_WIN_LO && mem_req_o.addr < RAM_WIN_HI))
		else $error("CPU write outside the RAM window");

endmodule

`default_nettype wire

// ==== hw/led_port.sv ====
/*
 * Debug LED port
 * Byte latch written and read on the top I/O port, LED lit while
 * the latch holds a nonzero value
 */
`timescale 1ns/1ps
`default_nettype none

module led_port import lm80c_pkg::*; (
	input  logic     ram_clock,
	input  logic     RESET,
	input  logic     hit_i,
	input  cpu_bus_t bus_i,
	output data_t    latch_o,
	output logic     led_o
);

	// Aligned with the registered hit
	cpu_bus_t bus_q;

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			bus_q   <= '0;
			latch_o <= '0;
		end else begin
			bus_q <= bus_i;
			// OUT (0xFF),A
			if (hit_i && bus_q.wr) begin
				latch_o <= bus_q.wdata;
			end
		end
	end

	assign led_o = |latch_o;

endmodule

`default_nettype wire

// ==== hw/io_slot.sv ====
/*
 * Peripheral slot
 * Drives active low read and write strobes for one external chip
 * and captures its read byte while the read strobe is low
 */
`timescale 1ns/1ps
`default_nettype none

module io_slot import lm80c_pkg::*; #(
	parameter slot_idx_t SLOT = '0
) (
	input  logic     ram_clock,
	input  logic     RESET,
	input  logic     hit_i,
	input  cpu_bus_t bus_i,
	input  data_t    periph_rdata_i,
	output logic     rd_n_o,
	output logic     wr_n_o,
	output data_t    rdata_o
);

	// Bus state that the registered hit was decoded from
	cpu_bus_t bus_q;

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			bus_q  <= '0;
			rd_n_o <= 1'b1;
			wr_n_o <= 1'b1;
		end else begin
			bus_q  <= bus_i;
			// Strobes one cycle after the hit
			rd_n_o <= ~(hit_i & bus_q.rd);
			wr_n_o <= ~(hit_i & bus_q.wr);
		end
	end

	// Sample the chip while it is being read, hold otherwise
	always_ff @(posedge ram_clock) begin
		if (!rd_n_o) begin
			rdata_o <= periph_rdata_i;
		end
	end

	// Z80 never reads and writes in the same cycle
	a_strobe_excl : assert property (@(posedge ram_clock) disable iff (RESET)
		!(!rd_n_o && !wr_n_o))
		else $error("Slot %0d read and write strobes both low", SLOT);

	// Decoder hit must match this slot's port nibble
	a_hit_port : assert property (@(posedge ram_clock) disable iff (RESET)
		hit_i |-> (bus_q.addr[7:4] == 4'(SLOT)))
		else $error("Slot %0d hit on a foreign port", SLOT);

endmodule

`default_nettype wire

// ==== hw/io_decoder.sv ====
/*
 * I/O and memory decoder
 * Registers slot hits from port bits 7..4, the LED port hit and the
 * writable RAM window hit, one cycle after the bus state
 */
`timescale 1ns/1ps
`default_nettype none

module io_decoder import lm80c_pkg::*; (
	input  logic       ram_clock,
	input  logic       RESET,
	input  cpu_bus_t   bus_i,
	output slot_mask_t slot_hit_o,
	output logic       led_hit_o,
	output logic       ram_win_hit_o
);

	logic       io_cycle;
	logic       mem_cycle;
	slot_mask_t slot_hit_d;
	logic       led_hit_d;
	logic       ram_win_d;

	// I/O cycle only without a memory request
	assign io_cycle  = bus_i.iorq & ~bus_i.mreq;
	assign mem_cycle = bus_i.mreq;

	// One slot per upper nibble of the port
	always_comb begin
		for (int i = 0; i < NUM_IO_SLOTS; i++) begin
			slot_hit_d[i] = io_cycle && (bus_i.addr[7:4] == 4'(i));
		end
	end

	// LED port needs the full low byte
	assign led_hit_d = io_cycle && (bus_i.addr[7:0] == LED_PORT);

	// Window upper bound is exclusive
	assign ram_win_d = mem_cycle && (bus_i.addr >= RAM_WIN_LO) && (bus_i.addr < RAM_WIN_HI);

	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			slot_hit_o    <= '0;
			led_hit_o     <= 1'b0;
			ram_win_hit_o <= 1'b0;
		end else begin
			slot_hit_o    <= slot_hit_d;
			led_hit_o     <= led_hit_d;
			ram_win_hit_o <= ram_win_d;
		end
	end

	// Slots, LED port and RAM window never overlap in the map
	a_slot_onehot : assert property (@(posedge ram_clock) disable iff (RESET)
		$onehot0({slot_hit_o, led_hit_o, ram_win_hit_o}))
		else $error("Overlapping decoder hits");

endmodule

`default_nettype wire

// ==== hw/clock_enable_gen.sv ====
/*
 * Clock enable generator
 * Eight phase counter on the RAM clock, VDP enable on every second
 * phase and CPU enable on every fourth
 */
`timescale 1ns/1ps
`default_nettype none

module clock_enable_gen import lm80c_pkg::*; (
	input  logic ram_clock,
	input  logic RESET,
	output logic cpu_ce_o,
	output logic vdp_ce_o
);

	localparam int CNT_W = $clog2(CE_PHASES);

	logic [CNT_W-1:0] phase_q;

	// Wraps after the last phase
	always_ff @(posedge ram_clock) begin
		if (RESET) begin
			phase_q <= '0;
		end else if (phase_q == CNT_W'(CE_PHASES - 1)) begin
			phase_q <= '0;
		end else begin
			phase_q <= phase_q + 1'b1;
		end
	end

	// Even phases for the VDP
	assign vdp_ce_o = ~phase_q[0];
	// Phases 0 and 4 for the CPU
	assign cpu_ce_o = (phase_q[1:0] == 2'b00);

	// CPU enable lands on a VDP phase, after one idle and one VDP phase
	a_cpu_ce_in_vdp_ce : assert property (@(posedge ram_clock) disable iff (RESET)
		$rose(cpu_ce_o) |-> vdp_ce_o && !$past(vdp_ce_o) && $past(vdp_ce_o, 2))
		else $error("cpu_ce_o rose off the vdp_ce_o cadence");

endmodule

`default_nettype wire

// ==== hw/lm80c_pkg.sv ====
/*
 * LM80C bus glue shared definitions
 * Bus widths, memory map, I/O slot count and the packed bus structs
 * used between the CPU side, the downloader and system RAM
 */
`default_nettype none

package lm80c_pkg;

	// Base bus widths
	typedef logic [15:0] addr_t;
	typedef logic [7:0]  data_t;

	// PIO, CTC, SIO, VDP and PSG on ports 0x00, 0x10 .. 0x40
	localparam int NUM_IO_SLOTS = 5;
	// CTC answers interrupt acknowledge with its vector
	localparam int CTC_SLOT = 1;
	// Debug LED latch sits on the last port
	localparam data_t LED_PORT = 8'hFF;

	// Writable RAM window, everything below is ROM image
	localparam addr_t RAM_WIN_LO = 16'h8000;
	localparam addr_t RAM_WIN_HI = 16'hC000;

	// Phases of the RAM clock per CPU enable cycle pair
	localparam int CE_PHASES = 8;

	typedef logic [2:0]              slot_idx_t;
	typedef logic [NUM_IO_SLOTS-1:0] slot_mask_t;

	// One CPU bus state, strobes already active high
	typedef struct packed {
		addr_t addr;
		data_t wdata;
		logic  rd;
		logic  wr;
		logic  iorq;
		logic  mreq;
		logic  m1;
	} cpu_bus_t;

	// One beat from the ROM downloader
	typedef struct packed {
		logic  active;
		addr_t addr;
		data_t data;
		logic  wr;
	} load_req_t;

	// Request seen by system RAM
	typedef struct packed {
		addr_t addr;
		data_t data;
		logic  wr;
	} mem_req_t;

	// RAM owner
	typedef enum logic {
		OWNER_LOADER,
		OWNER_CPU
	} owner_e;

endpackage

`default_nettype wire
